// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing -Wno-fatal
TOP       = tb_cpu
FILELIST  = filelist.f
OBJ_DIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '** PASS **'

clean:
	rm -rf $(OBJ_DIR)

// File: filelist.f
src/cpu_pkg.sv
src/cpu_fetch.sv
src/cpu_decode.sv
src/cpu_exec.sv
src/cpu_memory.sv
src/cpu_regfile.sv
src/cpu_core.sv
testbench/tb_bus_model.sv
testbench/tb_cpu.sv

// File: src/cpu_core.sv
module cpu_core #(
	parameter logic [cpu_pkg::addr_w-1:0] reset_pc = '0
) (
	input  logic                        clk,
	input  logic                        rst_n,
	output logic [cpu_pkg::addr_w-1:0]  i_addr,
	input  logic [cpu_pkg::data_w-1:0]  i_data,
	output logic [cpu_pkg::addr_w-1:0]  d_addr,
	output logic                        d_wr_en,
	output logic [cpu_pkg::data_w-1:0]  d_wr_val,
	input  logic [cpu_pkg::data_w-1:0]  d_data,
	output logic                        d_access,
	input  logic                        d_ack,
	input  logic                        d_error,
	output logic                        halted
);

	logic [cpu_pkg::data_w-1:0] fd_instr;
	logic [cpu_pkg::addr_w-1:0] fd_pc_plus_4;
	logic df_fetch_stall;
	logic df_is_halt;

	logic [cpu_pkg::reg_sel_w-1:0] dec_ra_sel;
	logic [cpu_pkg::reg_sel_w-1:0] dec_rb_sel;
	logic [cpu_pkg::reg_sel_w-1:0] e_ra_sel;
	logic [cpu_pkg::reg_sel_w-1:0] e_rb_sel;
	logic [cpu_pkg::data_w-1:0] rf_ra;
	logic [cpu_pkg::data_w-1:0] rf_rb;
	logic [cpu_pkg::data_w-1:0] ex_ra;
	logic [cpu_pkg::data_w-1:0] ex_rb;

	logic [cpu_pkg::reg_sel_w-1:0] de_rd_sel;
	logic de_update_rd;
	logic [cpu_pkg::data_w-1:0] de_imm32;
	cpu_pkg::alu_op_t de_alu_op;
	logic de_alu_src_imm;
	cpu_pkg::branch_kind_t de_branch_kind;
	logic de_mem_load;
	logic de_mem_store;
	logic [cpu_pkg::addr_w-1:0] de_pc_plus_4;

	logic [cpu_pkg::data_w-1:0] em_alu_out;
	logic [cpu_pkg::data_w-1:0] em_wr_val;
	logic [cpu_pkg::reg_sel_w-1:0] em_rd_sel;
	logic em_update_rd;
	logic em_mem_load;
	logic em_mem_store;
	logic ef_branch_taken;
	logic [cpu_pkg::addr_w-1:0] ef_branch_pc;
	logic ef_stall_clear;

	logic [cpu_pkg::data_w-1:0] mw_wr_val;
	logic mw_update_rd;
	logic [cpu_pkg::reg_sel_w-1:0] mw_rd_sel;
	logic mf_complete;

	cpu_fetch #(.reset_pc(reset_pc)) fetch (.clk(clk), .rst_n(rst_n),
		.fetch_stall(df_fetch_stall), .is_halt(df_is_halt),
		.stall_clear(ef_stall_clear), .complete(mf_complete),
		.branch_taken(ef_branch_taken), .branch_pc(ef_branch_pc),
		.fetch_addr(i_addr), .fetch_data(i_data), .instr(fd_instr),
		.pc_plus_4(fd_pc_plus_4), .halted(halted));

	cpu_decode decode (.clk(clk), .rst_n(rst_n), .instr(fd_instr),
		.pc_plus_4(fd_pc_plus_4), .ra_sel(dec_ra_sel), .rb_sel(dec_rb_sel),
		.rd_sel(de_rd_sel), .update_rd(de_update_rd), .imm32(de_imm32),
		.alu_op(de_alu_op), .alu_src_imm(de_alu_src_imm),
		.branch_kind(de_branch_kind), .mem_load(de_mem_load),
		.mem_store(de_mem_store), .pc_plus_4_out(de_pc_plus_4),
		.fetch_stall(df_fetch_stall), .is_halt(df_is_halt));

	cpu_exec execute (.clk(clk), .rst_n(rst_n), .ra(ex_ra), .rb(ex_rb),
		.imm32(de_imm32), .pc_plus_4(de_pc_plus_4), .rd_sel(de_rd_sel),
		.update_rd(de_update_rd), .alu_op(de_alu_op),
		.alu_src_imm(de_alu_src_imm), .branch_kind(de_branch_kind),
		.mem_load(de_mem_load), .mem_store(de_mem_store),
		.alu_out(em_alu_out), .wr_val(em_wr_val), .rd_sel_out(em_rd_sel),
		.update_rd_out(em_update_rd), .mem_load_out(em_mem_load),
		.mem_store_out(em_mem_store), .branch_taken(ef_branch_taken),
		.branch_pc(ef_branch_pc), .stall_clear(ef_stall_clear));

	cpu_memory mem (.clk(clk), .rst_n(rst_n), .load(em_mem_load),
		.store(em_mem_store), .addr(em_alu_out), .wr_val(em_wr_val),
		.update_rd(em_update_rd), .rd_sel(em_rd_sel),
		.reg_wr_val(mw_wr_val), .update_rd_out(mw_update_rd),
		.rd_sel_out(mw_rd_sel), .complete(mf_complete), .d_addr(d_addr),
		.d_wr_en(d_wr_en), .d_wr_val(d_wr_val), .d_data(d_data),
		.d_access(d_access), .d_ack(d_ack), .d_error(d_error));

	// reads use the selects of the instruction now in execute.
	cpu_regfile regfile (.clk(clk), .ra_sel(e_ra_sel), .rb_sel(e_rb_sel),
		.rd_sel(mw_rd_sel), .wr_en(mw_update_rd), .wr_val(mw_wr_val),
		.ra(rf_ra), .rb(rf_rb));

	always_ff @(posedge clk) begin
		e_ra_sel <= dec_ra_sel;
		e_rb_sel <= dec_rb_sel;
	end

	// the newer result wins when both later stages write the same register.
	always_comb begin
		if (em_update_rd && em_rd_sel == e_ra_sel)
			ex_ra = em_alu_out;
		else if (mw_update_rd && mw_rd_sel == e_ra_sel)
			ex_ra = mw_wr_val;
		else
			ex_ra = rf_ra;

		if (em_update_rd && em_rd_sel == e_rb_sel)
			ex_rb = em_alu_out;
		else if (mw_update_rd && mw_rd_sel == e_rb_sel)
			ex_rb = mw_wr_val;
		else
			ex_rb = rf_rb;
	end

endmodule

// File: src/cpu_decode.sv
module cpu_decode (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic [cpu_pkg::data_w-1:0]     instr,
	input  logic [cpu_pkg::addr_w-1:0]     pc_plus_4,
	output logic [cpu_pkg::reg_sel_w-1:0]  ra_sel,
	output logic [cpu_pkg::reg_sel_w-1:0]  rb_sel,
	output logic [cpu_pkg::reg_sel_w-1:0]  rd_sel,
	output logic                           update_rd,
	output logic [cpu_pkg::data_w-1:0]     imm32,
	output cpu_pkg::alu_op_t               alu_op,
	output logic                           alu_src_imm,
	output cpu_pkg::branch_kind_t          branch_kind,
	output logic                           mem_load,
	output logic                           mem_store,
	output logic [cpu_pkg::addr_w-1:0]     pc_plus_4_out,
	output logic                           fetch_stall,
	output logic                           is_halt
);

	cpu_pkg::opcode_t opcode;
	logic [cpu_pkg::data_w-1:0] imm_sext;
	logic [cpu_pkg::data_w-1:0] nxt_imm;
	cpu_pkg::alu_op_t nxt_alu_op;
	cpu_pkg::branch_kind_t nxt_branch;
	logic nxt_src_imm;
	logic nxt_update;
	logic nxt_load;
	logic nxt_store;

	assign opcode = cpu_pkg::opcode_t'(instr[31:27]);
	assign ra_sel = instr[22:19];
	assign rb_sel = instr[18:15];
	assign imm_sext = {{(cpu_pkg::data_w - 15){instr[14]}}, instr[14:0]};

	always_comb begin
		nxt_alu_op = cpu_pkg::alu_add;
		nxt_branch = cpu_pkg::br_none;
		nxt_imm = imm_sext;
		nxt_src_imm = 1'b0;
		nxt_update = 1'b0;
		nxt_load = 1'b0;
		nxt_store = 1'b0;
		fetch_stall = 1'b0;
		is_halt = 1'b0;
		case (opcode)
		cpu_pkg::op_add: nxt_update = 1'b1;
		cpu_pkg::op_sub: begin
			nxt_alu_op = cpu_pkg::alu_sub;
			nxt_update = 1'b1;
		end
		cpu_pkg::op_and: begin
			nxt_alu_op = cpu_pkg::alu_and;
			nxt_update = 1'b1;
		end
		cpu_pkg::op_or: begin
			nxt_alu_op = cpu_pkg::alu_or;
			nxt_update = 1'b1;
		end
		cpu_pkg::op_xor: begin
			nxt_alu_op = cpu_pkg::alu_xor;
			nxt_update = 1'b1;
		end
		cpu_pkg::op_lsl: begin
			nxt_alu_op = cpu_pkg::alu_lsl;
			nxt_update = 1'b1;
		end
		cpu_pkg::op_lsr: begin
			nxt_alu_op = cpu_pkg::alu_lsr;
			nxt_update = 1'b1;
		end
		cpu_pkg::op_addi: begin
			nxt_src_imm = 1'b1;
			nxt_update = 1'b1;
		end
		cpu_pkg::op_movhi: begin
			nxt_alu_op = cpu_pkg::alu_pass_b;
			nxt_imm = {imm_sext[15:0], 16'h0000};
			nxt_src_imm = 1'b1;
			nxt_update = 1'b1;
		end
		cpu_pkg::op_ldw: begin
			nxt_src_imm = 1'b1; // address is ra plus the immediate.
			nxt_update = 1'b1;
			nxt_load = 1'b1;
			fetch_stall = 1'b1;
		end
		cpu_pkg::op_stw: begin
			nxt_src_imm = 1'b1;
			nxt_store = 1'b1;
			fetch_stall = 1'b1;
		end
		cpu_pkg::op_beq: begin
			nxt_branch = cpu_pkg::br_eq;
			fetch_stall = 1'b1;
		end
		cpu_pkg::op_bne: begin
			nxt_branch = cpu_pkg::br_ne;
			fetch_stall = 1'b1;
		end
		cpu_pkg::op_b: begin
			nxt_branch = cpu_pkg::br_always;
			fetch_stall = 1'b1;
		end
		cpu_pkg::op_halt: begin
			fetch_stall = 1'b1;
			is_halt = 1'b1; // goes on down the pipe as a no-op.
		end
		default: ; // undefined opcodes fall through as no-ops.
		endcase
	end

	always_ff @(posedge clk) begin
		rd_sel <= instr[26:23];
		imm32 <= nxt_imm;
		alu_op <= nxt_alu_op;
		alu_src_imm <= nxt_src_imm;
		pc_plus_4_out <= pc_plus_4;
		if (!rst_n) begin
			update_rd <= 1'b0;
			branch_kind <= cpu_pkg::br_none;
			mem_load <= 1'b0;
			mem_store <= 1'b0;
		end else begin
			update_rd <= nxt_update;
			branch_kind <= nxt_branch;
			mem_load <= nxt_load;
			mem_store <= nxt_store;
		end
	end

endmodule

// File: src/cpu_exec.sv
module cpu_exec (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic [cpu_pkg::data_w-1:0]     ra,
	input  logic [cpu_pkg::data_w-1:0]     rb,
	input  logic [cpu_pkg::data_w-1:0]     imm32,
	input  logic [cpu_pkg::addr_w-1:0]     pc_plus_4,
	input  logic [cpu_pkg::reg_sel_w-1:0]  rd_sel,
	input  logic                           update_rd,
	input  cpu_pkg::alu_op_t               alu_op,
	input  logic                           alu_src_imm,
	input  cpu_pkg::branch_kind_t          branch_kind,
	input  logic                           mem_load,
	input  logic                           mem_store,
	output logic [cpu_pkg::data_w-1:0]     alu_out,
	output logic [cpu_pkg::data_w-1:0]     wr_val,
	output logic [cpu_pkg::reg_sel_w-1:0]  rd_sel_out,
	output logic                           update_rd_out,
	output logic                           mem_load_out,
	output logic                           mem_store_out,
	output logic                           branch_taken,
	output logic [cpu_pkg::addr_w-1:0]     branch_pc,
	output logic                           stall_clear
);

	localparam int shamt_w = $clog2(cpu_pkg::data_w);

	logic [cpu_pkg::data_w-1:0] op_b;
	logic [cpu_pkg::data_w-1:0] result;
	logic taken;

	assign op_b = alu_src_imm ? imm32 : rb;

	always_comb begin
		case (alu_op)
		cpu_pkg::alu_add: result = ra + op_b;
		cpu_pkg::alu_sub: result = ra - op_b;
		cpu_pkg::alu_and: result = ra & op_b;
		cpu_pkg::alu_or:  result = ra | op_b;
		cpu_pkg::alu_xor: result = ra ^ op_b;
		cpu_pkg::alu_lsl: result = ra << op_b[shamt_w-1:0];
		cpu_pkg::alu_lsr: result = ra >> op_b[shamt_w-1:0];
		default:          result = op_b; // move-high passes the shifted immediate.
		endcase
	end

	always_comb begin
		case (branch_kind)
		cpu_pkg::br_eq:     taken = (ra == rb);
		cpu_pkg::br_ne:     taken = (ra != rb);
		cpu_pkg::br_always: taken = 1'b1;
		default:            taken = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		alu_out <= result;
		wr_val <= rb; // store data.
		rd_sel_out <= rd_sel;
		branch_pc <= pc_plus_4 + imm32[cpu_pkg::addr_w-1:0];
		if (!rst_n) begin
			update_rd_out <= 1'b0;
			mem_load_out <= 1'b0;
			mem_store_out <= 1'b0;
			branch_taken <= 1'b0;
			stall_clear <= 1'b0;
		end else begin
			update_rd_out <= update_rd;
			mem_load_out <= mem_load;
			mem_store_out <= mem_store;
			branch_taken <= taken;
			stall_clear <= (branch_kind != cpu_pkg::br_none);
		end
	end

endmodule

// File: src/cpu_fetch.sv
module cpu_fetch #(
	parameter logic [cpu_pkg::addr_w-1:0] reset_pc = '0
) (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        fetch_stall,
	input  logic                        is_halt,
	input  logic                        stall_clear,
	input  logic                        complete,
	input  logic                        branch_taken,
	input  logic [cpu_pkg::addr_w-1:0]  branch_pc,
	output logic [cpu_pkg::addr_w-1:0]  fetch_addr,
	input  logic [cpu_pkg::data_w-1:0]  fetch_data,
	output logic [cpu_pkg::data_w-1:0]  instr,
	output logic [cpu_pkg::addr_w-1:0]  pc_plus_4,
	output logic                        halted
);

	logic [cpu_pkg::addr_w-1:0] pc;
	logic stalled;

	assign fetch_addr = pc; // the instruction bus answers in the same cycle.

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= reset_pc;
			stalled <= 1'b0;
			halted <= 1'b0;
			instr <= '0;
		end else if (halted) begin
			instr <= '0;
		end else if (is_halt) begin
			halted <= 1'b1; // nothing ever leaves this state.
			instr <= '0;
		end else if (stalled) begin
			instr <= '0; // decode sees no-ops until the stall is released.
			if (stall_clear || complete)
				stalled <= 1'b0;
			if (branch_taken)
				pc <= branch_pc;
		end else if (fetch_stall) begin
			stalled <= 1'b1; // the pc already points at the following word.
			instr <= '0;
		end else begin
			instr <= fetch_data;
			pc <= pc + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!stalled && !halted)
			pc_plus_4 <= pc + 1'b1;
	end

endmodule

// File: src/cpu_memory.sv
module cpu_memory (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           load,
	input  logic                           store,
	input  logic [cpu_pkg::data_w-1:0]     addr,
	input  logic [cpu_pkg::data_w-1:0]     wr_val,
	input  logic                           update_rd,
	input  logic [cpu_pkg::reg_sel_w-1:0]  rd_sel,
	output logic [cpu_pkg::data_w-1:0]     reg_wr_val,
	output logic                           update_rd_out,
	output logic [cpu_pkg::reg_sel_w-1:0]  rd_sel_out,
	output logic                           complete,
	output logic [cpu_pkg::addr_w-1:0]     d_addr,
	output logic                           d_wr_en,
	output logic [cpu_pkg::data_w-1:0]     d_wr_val,
	input  logic [cpu_pkg::data_w-1:0]     d_data,
	output logic                           d_access,
	input  logic                           d_ack,
	input  logic                           d_error
);

	cpu_pkg::mem_state_t state;
	logic load_pending;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= cpu_pkg::idle;
			d_access <= 1'b0;
			d_wr_en <= 1'b0;
			complete <= 1'b0;
			update_rd_out <= 1'b0;
			load_pending <= 1'b0;
		end else begin
			case (state)
			cpu_pkg::idle: begin
				if (load || store) begin
					state <= cpu_pkg::access;
					d_access <= 1'b1;
					d_wr_en <= store;
					load_pending <= load & update_rd;
					update_rd_out <= 1'b0; // held back until the data arrives.
				end else begin
					update_rd_out <= update_rd;
				end
			end
			cpu_pkg::access: begin
				if (d_ack || d_error) begin
					state <= cpu_pkg::done;
					d_access <= 1'b0;
					d_wr_en <= 1'b0;
					complete <= 1'b1;
					update_rd_out <= load_pending & ~d_error;
				end
			end
			default: begin
				state <= cpu_pkg::idle;
				complete <= 1'b0;
				update_rd_out <= 1'b0;
			end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == cpu_pkg::idle) begin
			d_addr <= addr[cpu_pkg::addr_w-1:0]; // the ALU result is a word address.
			d_wr_val <= wr_val;
			reg_wr_val <= addr;
			rd_sel_out <= rd_sel;
		end else if (state == cpu_pkg::access && d_ack) begin
			reg_wr_val <= d_data;
		end
	end

endmodule

// File: src/cpu_pkg.sv
package cpu_pkg;

	localparam int data_w = 32;
	localparam int addr_w = 30; // both buses carry word addresses.
	localparam int reg_sel_w = 4;

	// opcode zero is left undefined so that an all-zero word is a no-op.
	typedef enum logic [4:0] {
		op_add   = 5'h01,
		op_sub   = 5'h02,
		op_and   = 5'h03,
		op_or    = 5'h04,
		op_xor   = 5'h05,
		op_lsl   = 5'h06,
		op_lsr   = 5'h07,
		op_addi  = 5'h08,
		op_movhi = 5'h09,
		op_ldw   = 5'h0a,
		op_stw   = 5'h0b,
		op_beq   = 5'h0c,
		op_bne   = 5'h0d,
		op_b     = 5'h0e,
		op_halt  = 5'h0f
	} opcode_t;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_lsl,
		alu_lsr,
		alu_pass_b
	} alu_op_t;

	typedef enum logic [1:0] {
		br_none,
		br_eq,
		br_ne,
		br_always
	} branch_kind_t;

	typedef enum logic [1:0] {
		idle,
		access,
		done
	} mem_state_t;

endpackage

// File: src/cpu_regfile.sv
module cpu_regfile (
	input  logic                           clk,
	input  logic [cpu_pkg::reg_sel_w-1:0]  ra_sel,
	input  logic [cpu_pkg::reg_sel_w-1:0]  rb_sel,
	input  logic [cpu_pkg::reg_sel_w-1:0]  rd_sel,
	input  logic                           wr_en,
	input  logic [cpu_pkg::data_w-1:0]     wr_val,
	output logic [cpu_pkg::data_w-1:0]     ra,
	output logic [cpu_pkg::data_w-1:0]     rb
);

	localparam int num_regs = 2 ** cpu_pkg::reg_sel_w;

	logic [cpu_pkg::data_w-1:0] regs [num_regs] = '{default: '0};

	assign ra = regs[ra_sel];
	assign rb = regs[rb_sel];

	always_ff @(posedge clk) begin
		if (wr_en)
			regs[rd_sel] <= wr_val;
	end

endmodule

// File: testbench/tb_bus_model.sv
module tb_bus_model (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic [cpu_pkg::addr_w-1:0]  i_addr,
	output logic [cpu_pkg::data_w-1:0]  i_data,
	input  logic [cpu_pkg::addr_w-1:0]  d_addr,
	input  logic                        d_wr_en,
	input  logic [cpu_pkg::data_w-1:0]  d_wr_val,
	output logic [cpu_pkg::data_w-1:0]  d_data,
	input  logic                        d_access,
	output logic                        d_ack,
	output logic                        d_error
);

	timeunit 1ns;
	timeprecision 1ps;

	logic [cpu_pkg::data_w-1:0] rom [64] = '{default: '0};
	logic [cpu_pkg::data_w-1:0] ram [logic [cpu_pkg::addr_w-1:0]];
	logic [cpu_pkg::data_w-1:0] rd_q = '0;
	logic ack_q = 1'b0;
	logic err_q = 1'b0;
	logic waiting = 1'b0;
	int delay = 0;

	assign i_data = (i_addr < 30'd64) ? rom[i_addr[5:0]] : '0; // outside the rom reads as no-op.
	assign d_data = rd_q;
	assign d_ack = ack_q;
	assign d_error = err_q;

	// words never written read back as a mix of every address bit.
	function automatic logic [cpu_pkg::data_w-1:0] fill_word(input logic [cpu_pkg::addr_w-1:0] a);
		return {a[13:0], 2'b01, a[29:14]} ^ 32'h5a5a_c3c3;
	endfunction

	always @(posedge clk) begin
		#2;
		ack_q = 1'b0;
		err_q = 1'b0;
		if (!rst_n) begin
			ram.delete();
			waiting = 1'b0;
		end else if (d_access) begin
			if (!waiting) begin
				waiting = 1'b1;
				delay = $urandom_range(3, 0);
			end
			if (delay == 0) begin
				waiting = 1'b0;
				if (d_addr >= 30'h8000) begin
					err_q = 1'b1; // the upper region has no memory behind it.
				end else begin
					ack_q = 1'b1;
					if (d_wr_en)
						ram[d_addr] = d_wr_val;
					else
						rd_q = ram.exists(d_addr) ? ram[d_addr] : fill_word(d_addr);
				end
			end else begin
				delay--;
			end
		end
	end

endmodule

// File: testbench/tb_cpu.sv
module tb_cpu;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int num_tests = 7;
	localparam int max_words = 24;
	localparam int max_stores = 12;

	logic clk;
	logic rst_n;
	logic [cpu_pkg::addr_w-1:0] i_addr;
	logic [cpu_pkg::data_w-1:0] i_data;
	logic [cpu_pkg::addr_w-1:0] d_addr;
	logic d_wr_en;
	logic [cpu_pkg::data_w-1:0] d_wr_val;
	logic [cpu_pkg::data_w-1:0] d_data;
	logic d_access;
	logic d_ack;
	logic d_error;
	logic halted;

	string names [num_tests];
	logic [31:0] progs [num_tests][max_words];
	int prog_len [num_tests];
	logic [29:0] exp_addr [num_tests][max_stores];
	logic [31:0] exp_val [num_tests][max_stores];
	int exp_n [num_tests];
	int cur;

	logic [29:0] log_addr [$];
	logic [31:0] log_val [$];
	int pass_cnt;
	int fail_cnt;

	cpu_core #(.reset_pc(30'd16)) dut (.clk(clk), .rst_n(rst_n), .i_addr(i_addr),
		.i_data(i_data), .d_addr(d_addr), .d_wr_en(d_wr_en), .d_wr_val(d_wr_val),
		.d_data(d_data), .d_access(d_access), .d_ack(d_ack), .d_error(d_error),
		.halted(halted));

	tb_bus_model bus (.clk(clk), .rst_n(rst_n), .i_addr(i_addr), .i_data(i_data),
		.d_addr(d_addr), .d_wr_en(d_wr_en), .d_wr_val(d_wr_val), .d_data(d_data),
		.d_access(d_access), .d_ack(d_ack), .d_error(d_error));

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// a store counts once, in the cycle its acknowledge is seen.
	always @(posedge clk) begin
		if (rst_n && d_access && d_wr_en && d_ack) begin
			log_addr.push_back(d_addr);
			log_val.push_back(d_wr_val);
		end
	end

	function automatic logic [31:0] instr_word(input cpu_pkg::opcode_t op, input int rd,
		input int ra, input int rb, input int imm);
		return {op, 4'(rd), 4'(ra), 4'(rb), 15'(imm)};
	endfunction

	task automatic begin_test(input string name);
		cur++;
		names[cur] = name;
		prog_len[cur] = 0;
		exp_n[cur] = 0;
	endtask

	task automatic emit(input logic [31:0] w);
		progs[cur][prog_len[cur]] = w;
		prog_len[cur]++;
	endtask

	task automatic expect_store(input logic [29:0] a, input logic [31:0] v);
		exp_addr[cur][exp_n[cur]] = a;
		exp_val[cur][exp_n[cur]] = v;
		exp_n[cur]++;
	endtask

	task automatic build_table();
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] v1;
		logic [31:0] v2;
		logic [31:0] v3;
		logic [31:0] v4;
		logic [31:0] v5;
		cur = -1;
		a = 32'd1000;
		b = -32'sd37;
		begin_test("alu_ops");
		emit(instr_word(cpu_pkg::op_xor, 0, 0, 0, 0));
		emit(instr_word(cpu_pkg::op_addi, 1, 0, 0, 1000));
		emit(instr_word(cpu_pkg::op_addi, 2, 0, 0, -37));
		emit(instr_word(cpu_pkg::op_add, 3, 1, 2, 0));
		emit(instr_word(cpu_pkg::op_sub, 4, 1, 2, 0));
		emit(instr_word(cpu_pkg::op_and, 5, 1, 2, 0));
		emit(instr_word(cpu_pkg::op_or, 6, 1, 2, 0));
		emit(instr_word(cpu_pkg::op_xor, 7, 1, 2, 0));
		emit(instr_word(cpu_pkg::op_addi, 8, 0, 0, 4));
		emit(instr_word(cpu_pkg::op_lsl, 9, 1, 8, 0));
		emit(instr_word(cpu_pkg::op_lsr, 10, 2, 8, 0));
		emit(instr_word(cpu_pkg::op_movhi, 11, 0, 0, 16'h1234));
		for (int r = 1; r <= 11; r++) begin
			if (r != 8)
				emit(instr_word(cpu_pkg::op_stw, 0, 0, r, 16'h100 + r));
		end
		emit(instr_word(cpu_pkg::op_halt, 0, 0, 0, 0));
		expect_store(30'h101, a);
		expect_store(30'h102, b);
		expect_store(30'h103, a + b);
		expect_store(30'h104, a - b);
		expect_store(30'h105, a & b);
		expect_store(30'h106, a | b);
		expect_store(30'h107, a ^ b);
		expect_store(30'h109, a << 4);
		expect_store(30'h10a, b >> 4);
		expect_store(30'h10b, 32'h1234 << 16);

		begin_test("forward_chain");
		emit(instr_word(cpu_pkg::op_xor, 0, 0, 0, 0));
		emit(instr_word(cpu_pkg::op_addi, 1, 0, 0, 5));
		emit(instr_word(cpu_pkg::op_addi, 2, 1, 0, 7));
		emit(instr_word(cpu_pkg::op_add, 3, 2, 1, 0));
		emit(instr_word(cpu_pkg::op_sub, 4, 3, 2, 0));
		emit(instr_word(cpu_pkg::op_lsl, 5, 4, 1, 0));
		emit(instr_word(cpu_pkg::op_xor, 6, 5, 3, 0));
		emit(instr_word(cpu_pkg::op_stw, 0, 0, 6, 16'h200));
		emit(instr_word(cpu_pkg::op_stw, 0, 0, 3, 16'h201));
		emit(instr_word(cpu_pkg::op_stw, 0, 0, 4, 16'h202));
		emit(instr_word(cpu_pkg::op_halt, 0, 0, 0, 0));
		v1 = 32'd5;
		v2 = v1 + 32'd7;
		v3 = v2 + v1;
		v4 = v3 - v2;
		v5 = v4 << v1;
		expect_store(30'h200, v5 ^ v3);
		expect_store(30'h201, v3);
		expect_store(30'h202, v4);

		begin_test("store_load");
		emit(instr_word(cpu_pkg::op_xor, 0, 0, 0, 0));
		emit(instr_word(cpu_pkg::op_addi, 1, 0, 0, 16'h300));
		emit(instr_word(cpu_pkg::op_movhi, 2, 0, 0, 16'h00ab));
		emit(instr_word(cpu_pkg::op_addi, 2, 2, 0, 16'h00cd));
		emit(instr_word(cpu_pkg::op_addi, 3, 0, 0, -2));
		emit(instr_word(cpu_pkg::op_stw, 0, 1, 2, 0));
		emit(instr_word(cpu_pkg::op_stw, 0, 1, 3, 1));
		emit(instr_word(cpu_pkg::op_ldw, 4, 1, 0, 0));
		emit(instr_word(cpu_pkg::op_ldw, 5, 1, 0, 1));
		emit(instr_word(cpu_pkg::op_add, 6, 4, 5, 0));
		emit(instr_word(cpu_pkg::op_stw, 0, 1, 6, 2));
		emit(instr_word(cpu_pkg::op_stw, 0, 1, 5, 3));
		emit(instr_word(cpu_pkg::op_halt, 0, 0, 0, 0));
		v1 = (32'h00ab << 16) + 32'h00cd;
		expect_store(30'h300, v1);
		expect_store(30'h301, -32'sd2);
		expect_store(30'h302, v1 - 32'd2);
		expect_store(30'h303, -32'sd2);

		begin_test("branch_eq"); // the target is the next word plus the offset.
		emit(instr_word(cpu_pkg::op_xor, 0, 0, 0, 0));
		emit(instr_word(cpu_pkg::op_addi, 1, 0, 0, 3));
		emit(instr_word(cpu_pkg::op_addi, 2, 0, 0, 3));
		emit(instr_word(cpu_pkg::op_addi, 3, 0, 0, 4));
		emit(instr_word(cpu_pkg::op_addi, 9, 0, 0, 16'h400));
		emit(instr_word(cpu_pkg::op_beq, 0, 1, 2, 1));
		emit(instr_word(cpu_pkg::op_stw, 0, 9, 1, 0));
		emit(instr_word(cpu_pkg::op_stw, 0, 9, 1, 1));
		emit(instr_word(cpu_pkg::op_beq, 0, 1, 3, 1));
		emit(instr_word(cpu_pkg::op_stw, 0, 9, 3, 2));
		emit(instr_word(cpu_pkg::op_stw, 0, 9, 3, 3));
		emit(instr_word(cpu_pkg::op_halt, 0, 0, 0, 0));
		expect_store(30'h401, 32'd3);
		expect_store(30'h402, 32'd4);
		expect_store(30'h403, 32'd4);

		begin_test("branch_ne_b");
		emit(instr_word(cpu_pkg::op_xor, 0, 0, 0, 0));
		emit(instr_word(cpu_pkg::op_addi, 1, 0, 0, 3));
		emit(instr_word(cpu_pkg::op_addi, 2, 0, 0, 5));
		emit(instr_word(cpu_pkg::op_addi, 9, 0, 0, 16'h500));
		emit(instr_word(cpu_pkg::op_bne, 0, 1, 2, 1));
		emit(instr_word(cpu_pkg::op_stw, 0, 9, 1, 0));
		emit(instr_word(cpu_pkg::op_stw, 0, 9, 2, 1));
		emit(instr_word(cpu_pkg::op_bne, 0, 1, 1, 1));
		emit(instr_word(cpu_pkg::op_stw, 0, 9, 1, 2));
		emit(instr_word(cpu_pkg::op_b, 0, 0, 0, 2));
		emit(instr_word(cpu_pkg::op_stw, 0, 9, 1, 3));
		emit(instr_word(cpu_pkg::op_stw, 0, 9, 1, 4));
		emit(instr_word(cpu_pkg::op_stw, 0, 9, 2, 5));
		emit(instr_word(cpu_pkg::op_halt, 0, 0, 0, 0));
		expect_store(30'h501, 32'd5);
		expect_store(30'h502, 32'd3);
		expect_store(30'h505, 32'd5);

		begin_test("branch_loop");
		emit(instr_word(cpu_pkg::op_xor, 0, 0, 0, 0));
		emit(instr_word(cpu_pkg::op_xor, 1, 1, 1, 0));
		emit(instr_word(cpu_pkg::op_addi, 2, 0, 0, 3));
		emit(instr_word(cpu_pkg::op_addi, 3, 0, 0, 1));
		emit(instr_word(cpu_pkg::op_addi, 9, 0, 0, 16'h600));
		emit(instr_word(cpu_pkg::op_add, 1, 1, 2, 0));
		emit(instr_word(cpu_pkg::op_sub, 2, 2, 3, 0));
		emit(instr_word(cpu_pkg::op_bne, 0, 2, 0, -3)); // back to the add.
		emit(instr_word(cpu_pkg::op_stw, 0, 9, 1, 0));
		emit(instr_word(cpu_pkg::op_halt, 0, 0, 0, 0));
		expect_store(30'h600, 32'd3 + 32'd2 + 32'd1);

		begin_test("load_error");
		emit(instr_word(cpu_pkg::op_xor, 0, 0, 0, 0));
		emit(instr_word(cpu_pkg::op_addi, 4, 0, 0, 77));
		emit(instr_word(cpu_pkg::op_movhi, 8, 0, 0, 1));
		emit(instr_word(cpu_pkg::op_addi, 9, 0, 0, 16'h700));
		emit(instr_word(cpu_pkg::op_ldw, 4, 8, 0, 5));
		emit(instr_word(cpu_pkg::op_stw, 0, 9, 4, 0));
		emit(instr_word(cpu_pkg::op_addi, 5, 4, 0, 1));
		emit(instr_word(cpu_pkg::op_stw, 0, 9, 5, 1));
		emit(instr_word(cpu_pkg::op_halt, 0, 0, 0, 0));
		expect_store(30'h700, 32'd77);
		expect_store(30'h701, 32'd78);
	endtask

	task automatic run_test(input int t);
		int errs;
		errs = 0;
		for (int k = 0; k < 64; k++)
			bus.rom[k] = '0;
		for (int k = 0; k < prog_len[t]; k++)
			bus.rom[16 + k] = progs[t][k];
		rst_n = 1'b0;
		repeat (4) @(posedge clk);
		#2;
		log_addr.delete();
		log_val.delete();
		assert (d_access == 1'b0 && halted == 1'b0 && i_addr == 30'd16) else begin
			$display("[FAIL] %s: reset expected access/halted/pc 0/0/%h, actual %b/%b/%h",
				names[t], 30'd16, d_access, halted, i_addr);
			errs++;
		end
		rst_n = 1'b1;
		while (!halted) begin
			@(posedge clk);
			#2;
		end
		for (int i = 0; i < exp_n[t]; i++) begin
			assert (i < log_addr.size()) else begin
				$display("%s: store %0d to %h never reached the bus", names[t], i,
					exp_addr[t][i]);
				errs++;
			end
			if (i < log_addr.size()) begin
				assert (log_addr[i] == exp_addr[t][i] && log_val[i] == exp_val[t][i]) else begin
					$display("[FAIL] %s: store %0d expected %h <= %h, actual %h <= %h",
						names[t], i, exp_addr[t][i], exp_val[t][i], log_addr[i], log_val[i]);
					errs++;
				end
			end
		end
		assert (log_addr.size() <= exp_n[t]) else begin
			$display("%s: %0d stores appeared on the bus where %0d were expected", names[t],
				log_addr.size(), exp_n[t]);
			errs++;
		end
		if (errs == 0) begin
			pass_cnt++;
			$display("test %s passed", names[t]);
		end else begin
			fail_cnt++;
			$display("test %s failed with %0d errors", names[t], errs);
		end
	endtask

	initial begin
		#(num_tests * 200 * 40);
		$display("watchdog: the run took too long, a program never reached halt");
		$display("** FAIL **");
		$finish;
	end

	initial begin
		void'($urandom(32'h319c));
		rst_n = 1'b0;
		pass_cnt = 0;
		fail_cnt = 0;
		build_table();
		@(posedge clk);
		#2;
		for (int t = 0; t < num_tests; t++)
			run_test(t);
		$display("%0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
		if (fail_cnt == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule
